/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module digit_view_tb -o digit_view_sim
	@out="$$(./obj_dir/digit_view_sim)"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* bench/digit_view_assertions.sv */
`timescale 1ns/1ps

module digit_view_assertions (
    input logic       video_clk,
    input logic       rst_n,
    input logic       hs,
    input logic       vs,
    input logic       de,
    input logic [7:0] r,
    input logic [7:0] g,
    input logic [7:0] b
);

    int fail_cnt = 0;  // failed assertions so far

    // ------------------------------
    // sync against data enable
    // ------------------------------
    de_off_in_hsync: assert property (@(posedge video_clk) disable iff (!rst_n) !(de && hs))
        else begin
            $error("de high during hsync");
            fail_cnt++;
        end

    de_off_in_vsync: assert property (@(posedge video_clk) disable iff (!rst_n) !(de && vs))
        else begin
            $error("de high during vsync");
            fail_cnt++;
        end

    // blanking is black
    blank_outside_de: assert property (@(posedge video_clk) disable iff (!rst_n)
        !de |-> (r == 8'h00 && g == 8'h00 && b == 8'h00))
        else begin
            $error("colour not zero outside de");
            fail_cnt++;
        end

endmodule

bind digit_view_top digit_view_assertions u_digit_view_assertions (
    .video_clk (video_clk),
    .rst_n     (rst_n),
    .hs        (hs),
    .vs        (vs),
    .de        (de),
    .r         (r),
    .g         (g),
    .b         (b)
);

/* bench/digit_view_tb.sv */
`timescale 1ns/1ps
`include "digit_view_defines.svh"

module digit_view_tb;

    localparam int TIMEOUT_CYC = 3_000_000;                   // tests need about 6 frames
    localparam int CAM_SIZE    = 232;                         // camera lines and pixels
    localparam int LAT_STEP    = 1 << `DV_SAMPLE_SHIFT;       // lattice pitch
    localparam int WIN_SIZE    = `DV_GRID << `DV_BIN_SHIFT;   // 448 px window side
    localparam int CELL_MID    = 1 << (`DV_CLASS_SHIFT - 1);  // centre of a class cell
    localparam int BG_SAMPLES  = 200;

    logic                    video_clk = 1'b0;
    logic                    rst_n;
    logic                    cam_vsync;
    logic                    cam_href;
    logic                    cam_valid;
    digit_view_pkg::rgb565_t cam_pixel;
    logic [`DV_CLASSES-1:0]  class_vec;
    logic                    hs;
    logic                    vs;
    logic                    de;
    logic [7:0]              r;
    logic [7:0]              g;
    logic [7:0]              b;

    logic [31:0] rng;
    bit          exp_ink [`DV_GRID][`DV_GRID];  // [row][col] from first camera frame
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic        hs_q = 1'b0;                  // outputs one cycle back
    logic        vs_q = 1'b0;
    logic        de_q = 1'b0;
    logic        hs_rise;
    logic        vs_rise;
    logic        vs_fall;
    logic        de_rise;
    int          pix_x = 0;                    // output position, valid while de
    int          pix_y = 0;
    int          line_cnt = 0;                 // de lines since last vs

    always #5 video_clk = ~video_clk;

    digit_view_top dut (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .cam_valid (cam_valid),
        .cam_pixel (cam_pixel),
        .class_vec (class_vec),
        .hs        (hs),
        .vs        (vs),
        .de        (de),
        .r         (r),
        .g         (g),
        .b         (b)
    );

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic bit is_ink(input logic [15:0] w);
        int sum;
        sum = int'(w[15:11]) + int'(w[10:5]) + int'(w[4:0]);  // b, g, r
        return sum < `DV_THRESHOLD;
    endfunction

    function automatic bit in_grid_win(input int x, input int y);
        int cx;
        int cy;
        cx = x >> `DV_BIN_SHIFT;
        cy = y >> `DV_BIN_SHIFT;
        return cx >= `DV_BIN_X && cx < `DV_BIN_X + `DV_GRID &&
               cy >= `DV_BIN_Y && cy < `DV_BIN_Y + `DV_GRID;
    endfunction

    function automatic bit in_class_bar(input int x, input int y);
        int cx;
        cx = x >> `DV_CLASS_SHIFT;
        return cx >= `DV_CLASS_X && cx < `DV_CLASS_X + `DV_CLASSES &&
               (y >> `DV_CLASS_SHIFT) == `DV_CLASS_Y;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp_v,
                                input logic [31:0] got_v);
        errors++;
        $display("FAIL %0t %s expected %0d got %0d", $time, name, exp_v, got_v);
    endtask

    task automatic check_rgb(input logic [7:0] er, input logic [7:0] eg, input logic [7:0] eb);
        checks++;
        if (r !== er) report_value("r", er, r);
        if (g !== eg) report_value("g", eg, g);
        if (b !== eb) report_value("b", eb, b);
    endtask

    // one clock, then look at the outputs and update the raster position
    task automatic step();
        @(posedge video_clk);
        #1;
        hs_rise = hs && !hs_q;
        vs_rise = vs && !vs_q;
        vs_fall = !vs && vs_q;
        de_rise = de && !de_q;
        if (vs) line_cnt = 0;                // first de line after vs is y 0
        if (de) begin
            pix_x = de_rise ? 0 : pix_x + 1;
            pix_y = line_cnt;
        end
        if (de_q && !de) line_cnt++;
        hs_q = hs;
        vs_q = vs;
        de_q = de;
    endtask

    task automatic drive_cam_frame(input bit record, input bit close_vsync);
        logic [15:0] word;
        for (int ln = 0; ln < CAM_SIZE; ln++) begin
            cam_href = 1'b1;
            for (int px = 0; px < CAM_SIZE; px++) begin
                rng = xorshift32(rng);
                word = rng[16] ? (rng[15:0] & 16'h39e7) : rng[15:0];  // half forced dark
                cam_valid = 1'b1;
                cam_pixel.raw = word;
                if (record && ln % LAT_STEP == 0 && px % LAT_STEP == 0 &&
                    ln / LAT_STEP < `DV_GRID && px / LAT_STEP < `DV_GRID)
                    exp_ink[ln / LAT_STEP][px / LAT_STEP] = is_ink(word);
                step();
            end
            cam_href = 1'b0;
            cam_valid = 1'b0;
            repeat (2) step();                // line gap
        end
        if (close_vsync) begin
            cam_vsync = 1'b1;
            repeat (4) step();
            cam_vsync = 1'b0;
        end
    endtask

    task automatic check_grid_frame(input string what);
        int n;
        logic [7:0] e;
        n = 0;
        do begin
            step();
        end while (!vs_rise);                 // wait for the next display frame
        while (line_cnt < WIN_SIZE) begin
            step();
            if (de && in_grid_win(pix_x, pix_y)) begin
                e = exp_ink[(pix_y >> `DV_BIN_SHIFT) - `DV_BIN_Y]
                           [(pix_x >> `DV_BIN_SHIFT) - `DV_BIN_X] ? 8'hff : 8'h00;
                check_rgb(e, e, e);
                n++;
            end
        end
        if (n != WIN_SIZE * WIN_SIZE) begin
            errors++;
            $display("ERROR %0t %s: only %0d grid window pixels seen", $time, what, n);
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic check_reset();
        rst_n = 1'b0;
        for (int i = 0; i < 5; i++) begin    // 4 cycles in reset, 1 after
            if (i == 4) rst_n = 1'b1;
            step();
            if (hs !== 1'b0) report_value("hs", 0, hs);
            if (vs !== 1'b0) report_value("vs", 0, vs);
            if (de !== 1'b0) report_value("de", 0, de);
            check_rgb(8'h00, 8'h00, 8'h00);
        end
    endtask

    task automatic check_timing();
        int n;
        do begin
            step();
        end while (!hs_rise);
        n = 0;
        do begin
            step();
            n++;
        end while (!hs_rise);
        checks++;
        if (n != `DV_H_TOTAL) report_value("hs period", `DV_H_TOTAL, n);
        do begin
            step();
        end while (!de_rise);
        n = 0;
        while (de) begin                      // pixels on one active line
            n++;
            step();
        end
        checks++;
        if (n != `DV_H_ACTIVE) report_value("de per line", `DV_H_ACTIVE, n);
        do begin
            step();
        end while (!vs_fall);
        n = 0;
        do begin
            step();
            if (de_rise) n++;
        end while (!vs_rise);
        checks++;
        if (n != `DV_V_ACTIVE) report_value("de lines", `DV_V_ACTIVE, n);
    endtask

    task automatic check_capture();
        drive_cam_frame(1'b1, 1'b1);
        check_grid_frame("capture");
    endtask

    task automatic check_hold();
        drive_cam_frame(1'b0, 1'b0);          // new data, grid must not move
        check_grid_frame("hold");
    endtask

    task automatic check_class_bar();
        int n;
        logic [7:0] e;
        class_vec = 10'b1010011001;
        n = 0;
        while (n < `DV_CLASSES) begin
            step();
            if (de && !in_grid_win(pix_x, pix_y) && in_class_bar(pix_x, pix_y) &&
                pix_x % (2 * CELL_MID) == CELL_MID && pix_y % (2 * CELL_MID) == CELL_MID) begin
                e = class_vec[(pix_x >> `DV_CLASS_SHIFT) - `DV_CLASS_X] ? 8'hff : 8'h00;
                check_rgb(e, e, e);
                n++;
            end
        end
    endtask

    task automatic check_background();
        int n;
        n = 0;
        while (n < BG_SAMPLES) begin
            step();
            if (de && !in_grid_win(pix_x, pix_y) && !in_class_bar(pix_x, pix_y) &&
                pix_x % 8 == 3 && pix_y % 8 == 5) begin
                check_rgb(8'(pix_x), 8'(pix_y), 8'hff);  // gradient
                n++;
            end
        end
    endtask

    // watchdog
    always @(posedge video_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rng = 32'd53;
        rst_n = 1'b0;
        cam_vsync = 1'b0;
        cam_href = 1'b0;
        cam_valid = 1'b0;
        cam_pixel.raw = 16'h0000;
        class_vec = '0;
        check_reset();
        check_timing();
        check_capture();
        check_hold();
        check_class_bar();
        check_background();
        errors += dut.u_digit_view_assertions.fail_cnt;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+logic
logic/digit_view_pkg.sv
logic/cam_decimator.sv
logic/display_timing.sv
logic/overlay_mixer.sv
logic/digit_view_top.sv
bench/digit_view_assertions.sv
bench/digit_view_tb.sv

/* logic/cam_decimator.sv */
`timescale 1ns/1ps
`include "digit_view_defines.svh"

module cam_decimator (
    input  logic                        video_clk,
    input  logic                        rst_n,
    input  logic                        cam_vsync,  // high in frame blanking
    input  logic                        cam_href,   // high across one line
    input  logic                        cam_valid,  // one strobe per pixel
    input  digit_view_pkg::rgb565_t     cam_pixel,
    output digit_view_pkg::digit_grid_t grid        // frame latched at vsync
);

    localparam int LAT_W = `DV_COORD_W - `DV_SAMPLE_SHIFT;  // lattice index width
    localparam int CELLS = `DV_GRID * `DV_GRID;             // 784 samples

    logic [`DV_COORD_W-1:0] pix_idx;    // pixel within line
    logic [`DV_COORD_W-1:0] line_idx;   // line within frame
    logic                   href_q;     // href one cycle back
    logic                   href_fall;
    logic                   pix_on;     // pixel column on lattice
    logic                   line_on;    // line on lattice
    logic                   sample;     // take this pixel
    logic [7:0]             bright;     // r+g+b, max 125
    logic                   ink;        // dark enough to count
    logic [CELLS-1:0]       shr;        // fills from the top

    // ------------------------------
    // camera position
    // ------------------------------
    assign href_fall = href_q & ~cam_href;

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            href_q   <= 1'b0;
            pix_idx  <= '0;
            line_idx <= '0;
        end else begin
            href_q <= cam_href;

            if (!cam_href) begin
                pix_idx <= '0;              // restart every line
            end else if (cam_valid) begin
                pix_idx <= pix_idx + 1'b1;
            end

            if (cam_vsync) begin
                line_idx <= '0;             // first line is 0
            end else if (href_fall) begin
                line_idx <= line_idx + 1'b1; // next line after href drops
            end
        end
    end

    // ------------------------------
    // lattice and threshold
    // ------------------------------
    assign pix_on  = (pix_idx[`DV_SAMPLE_SHIFT-1:0] == '0) &&
                     (pix_idx[`DV_COORD_W-1:`DV_SAMPLE_SHIFT] < LAT_W'(`DV_GRID));
    assign line_on = (line_idx[`DV_SAMPLE_SHIFT-1:0] == '0) &&
                     (line_idx[`DV_COORD_W-1:`DV_SAMPLE_SHIFT] < LAT_W'(`DV_GRID));
    assign sample  = cam_valid & pix_on & line_on;

    // channel sum through the field view
    assign bright = 8'(cam_pixel.f.r) + 8'(cam_pixel.f.g) + 8'(cam_pixel.f.b);
    assign ink    = bright < 8'(`DV_THRESHOLD);

    // first sample of the frame ends up at bit 0 = [0][0]
    always_ff @(posedge video_clk) begin
        if (sample) begin
            shr <= {ink, shr[CELLS-1:1]};
        end
    end

    // copy out in blanking so the display sees whole frames only
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            grid <= '0;
        end else if (cam_vsync) begin
            grid <= shr;
        end
    end

endmodule

/* logic/digit_view_defines.svh */
`ifndef DIGIT_VIEW_DEFINES_SVH
`define DIGIT_VIEW_DEFINES_SVH

// ------------------------------
// display raster, 640x480 at 60 Hz
// ------------------------------
`define DV_H_ACTIVE     640     // visible pixels per line
`define DV_H_TOTAL      800     // pixels per line incl blanking
`define DV_HS_START     656     // first hsync pixel
`define DV_HS_END       752     // first pixel after hsync
`define DV_V_ACTIVE     480     // visible lines
`define DV_V_TOTAL      525     // lines per frame
`define DV_VS_START     490     // first vsync line
`define DV_VS_END       492     // first line after vsync
`define DV_COORD_W      10      // x/y and camera index width

// ------------------------------
// capture lattice and overlay
// ------------------------------
`define DV_GRID         28      // grid is 28 x 28
`define DV_SAMPLE_SHIFT 3       // every 8th pixel / line
`define DV_BIN_SHIFT    4       // 16 px grid cells
`define DV_BIN_X        2       // window origin, in cells
`define DV_BIN_Y        0
`define DV_CLASS_SHIFT  5       // 32 px class cells
`define DV_CLASS_X      1       // bar origin, in cells
`define DV_CLASS_Y      14
`define DV_CLASSES      10      // one cell per digit
`define DV_THRESHOLD    30      // r+g+b below this counts as ink

`endif

/* logic/digit_view_pkg.sv */
`include "digit_view_defines.svh"

package digit_view_pkg;

    // camera word, channels stored swapped as on the sensor bus
    typedef struct packed {
        logic [4:0] b;  // top bits
        logic [5:0] g;
        logic [4:0] r;  // bottom bits
    } rgb565_fields_t;

    // one 16 bit word, seen whole or split into channels
    typedef union packed {
        logic [15:0]    raw;    // word as it arrives
        rgb565_fields_t f;      // channel view for binarizing
    } rgb565_t;

    // binarized digit, [row][col], row major
    // bit [r][c] came from camera line 8*r, pixel 8*c
    typedef logic [`DV_GRID-1:0][`DV_GRID-1:0] digit_grid_t;

endpackage

/* logic/digit_view_top.sv */
`timescale 1ns/1ps
`include "digit_view_defines.svh"

module digit_view_top (
    input  logic                    video_clk,
    input  logic                    rst_n,
    input  logic                    cam_vsync,
    input  logic                    cam_href,
    input  logic                    cam_valid,
    input  digit_view_pkg::rgb565_t cam_pixel,
    input  logic [`DV_CLASSES-1:0]  class_vec,  // from the classifier
    output logic                    hs,
    output logic                    vs,
    output logic                    de,
    output logic [7:0]              r,
    output logic [7:0]              g,
    output logic [7:0]              b
);

    digit_view_pkg::digit_grid_t grid;     // latched capture
    logic                        tim_hs;
    logic                        tim_vs;
    logic                        tim_de;
    logic [`DV_COORD_W-1:0]      tim_x;
    logic [`DV_COORD_W-1:0]      tim_y;

    // ------------------------------
    // capture and binarize
    // ------------------------------
    cam_decimator u_cam_decimator (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .cam_valid (cam_valid),
        .cam_pixel (cam_pixel),
        .grid      (grid)
    );

    // raster generator
    display_timing u_display_timing (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .tim_hs    (tim_hs),
        .tim_vs    (tim_vs),
        .tim_de    (tim_de),
        .tim_x     (tim_x),
        .tim_y     (tim_y)
    );

    // grid, class bar and background
    overlay_mixer u_overlay_mixer (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .tim_hs    (tim_hs),
        .tim_vs    (tim_vs),
        .tim_de    (tim_de),
        .tim_x     (tim_x),
        .tim_y     (tim_y),
        .grid      (grid),
        .class_vec (class_vec),
        .hs        (hs),
        .vs        (vs),
        .de        (de),
        .r         (r),
        .g         (g),
        .b         (b)
    );

endmodule

/* logic/display_timing.sv */
`timescale 1ns/1ps
`include "digit_view_defines.svh"

module display_timing (
    input  logic                   video_clk,
    input  logic                   rst_n,
    output logic                   tim_hs,  // active high hsync
    output logic                   tim_vs,  // active high vsync
    output logic                   tim_de,  // visible area
    output logic [`DV_COORD_W-1:0] tim_x,   // pixel column
    output logic [`DV_COORD_W-1:0] tim_y    // line number
);

    logic [`DV_COORD_W-1:0] hcount;  // 0..799
    logic [`DV_COORD_W-1:0] vcount;  // 0..524
    logic                   h_last;
    logic                   v_last;

    assign h_last = hcount == `DV_COORD_W'(`DV_H_TOTAL - 1);
    assign v_last = vcount == `DV_COORD_W'(`DV_V_TOTAL - 1);

    // ------------------------------
    // raster counters
    // ------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (h_last) begin
                hcount <= '0;
                if (v_last) begin
                    vcount <= '0;           // new frame
                end else begin
                    vcount <= vcount + 1'b1;
                end
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // ------------------------------
    // registered sync, enable, coords
    // ------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            tim_hs <= 1'b0;
            tim_vs <= 1'b0;
            tim_de <= 1'b0;
            tim_x  <= '0;
            tim_y  <= '0;
        end else begin
            tim_hs <= (hcount >= `DV_COORD_W'(`DV_HS_START)) &&
                      (hcount <  `DV_COORD_W'(`DV_HS_END));
            tim_vs <= (vcount >= `DV_COORD_W'(`DV_VS_START)) &&
                      (vcount <  `DV_COORD_W'(`DV_VS_END));
            tim_de <= (hcount < `DV_COORD_W'(`DV_H_ACTIVE)) &&
                      (vcount < `DV_COORD_W'(`DV_V_ACTIVE));
            tim_x  <= hcount;               // same cycle as syncs
            tim_y  <= vcount;
        end
    end

endmodule

/* logic/overlay_mixer.sv */
`timescale 1ns/1ps
`include "digit_view_defines.svh"

module overlay_mixer (
    input  logic                        video_clk,
    input  logic                        rst_n,
    input  logic                        tim_hs,
    input  logic                        tim_vs,
    input  logic                        tim_de,
    input  logic [`DV_COORD_W-1:0]      tim_x,
    input  logic [`DV_COORD_W-1:0]      tim_y,
    input  digit_view_pkg::digit_grid_t grid,       // latched digit
    input  logic [`DV_CLASSES-1:0]      class_vec,  // one bit per class
    output logic                        hs,
    output logic                        vs,
    output logic                        de,
    output logic [7:0]                  r,
    output logic [7:0]                  g,
    output logic [7:0]                  b
);

    localparam int BIN_CW  = `DV_COORD_W - `DV_BIN_SHIFT;    // grid cell coord width
    localparam int CLS_CW  = `DV_COORD_W - `DV_CLASS_SHIFT;  // class cell coord width
    localparam int GRID_IW = $clog2(`DV_GRID);
    localparam int CLS_IW  = $clog2(`DV_CLASSES);

    logic [BIN_CW-1:0] bin_col;  // cell relative to window origin
    logic [BIN_CW-1:0] bin_row;
    logic              in_bin;
    logic              bin_bit;
    logic [CLS_CW-1:0] cls_col;  // cell relative to bar origin
    logic [CLS_CW-1:0] cls_row;
    logic              in_cls;
    logic              cls_bit;
    logic [7:0]        pix_r;
    logic [7:0]        pix_g;
    logic [7:0]        pix_b;

    // ------------------------------
    // window decode
    // ------------------------------
    // left of origin wraps to a large value and falls outside
    assign bin_col = tim_x[`DV_COORD_W-1:`DV_BIN_SHIFT] - BIN_CW'(`DV_BIN_X);
    assign bin_row = tim_y[`DV_COORD_W-1:`DV_BIN_SHIFT] - BIN_CW'(`DV_BIN_Y);
    assign in_bin  = (bin_col < BIN_CW'(`DV_GRID)) && (bin_row < BIN_CW'(`DV_GRID));
    assign bin_bit = grid[bin_row[GRID_IW-1:0]][bin_col[GRID_IW-1:0]];

    assign cls_col = tim_x[`DV_COORD_W-1:`DV_CLASS_SHIFT] - CLS_CW'(`DV_CLASS_X);
    assign cls_row = tim_y[`DV_COORD_W-1:`DV_CLASS_SHIFT];
    assign in_cls  = (cls_col < CLS_CW'(`DV_CLASSES)) && (cls_row == CLS_CW'(`DV_CLASS_Y));
    assign cls_bit = class_vec[cls_col[CLS_IW-1:0]];

    // ------------------------------
    // colour select
    // ------------------------------
    always_comb begin
        pix_r = tim_x[7:0];             // gradient background
        pix_g = tim_y[7:0];
        pix_b = 8'hff;
        if (!tim_de) begin
            pix_r = '0;                 // blank outside active area
            pix_g = '0;
            pix_b = '0;
        end else if (in_bin) begin
            pix_r = {8{bin_bit}};       // white ink on black
            pix_g = {8{bin_bit}};
            pix_b = {8{bin_bit}};
        end else if (in_cls) begin
            pix_r = {8{cls_bit}};
            pix_g = {8{cls_bit}};
            pix_b = {8{cls_bit}};
        end
    end

    // one stage, colour and syncs stay aligned
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            hs <= 1'b0;
            vs <= 1'b0;
            de <= 1'b0;
            r  <= '0;
            g  <= '0;
            b  <= '0;
        end else begin
            hs <= tim_hs;
            vs <= tim_vs;
            de <= tim_de;
            r  <= pix_r;
            g  <= pix_g;
            b  <= pix_b;
        end
    end

endmodule
